//--- compile.f
design/csu_pkg.sv
design/csu_decoder.sv
design/phys_regfile.sv
design/csr_file.sv
design/csu_pipe.sv
design/csu_top.sv
tb/tb_clock_gen.sv
tb/csu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the CSU testbench with Verilator, runs it and checks the log.
set -u

cd "$(dirname "$0")" || exit 1
log_file=sim.log

verilator --binary --timing --assert -f compile.f --top-module csu_tb \
  -Mdir obj_dir -o csu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed."
  exit 1
fi

./obj_dir/csu_sim > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if grep -q '\*\* FAIL \*\*' "$log_file"; then
  echo "Simulation reported a failure."
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status."
  exit 1
fi
echo "Simulation finished without failures."
exit 0

//--- tb/csu_tb.sv
`default_nettype none

module csu_tb;

  localparam int RV_ENTRY_SIZE = 8;
  localparam int TGT_BUS_SIZE  = 2;
  localparam int PHY_REGS      = 64;
  localparam int RW            = csu_pkg::RNID_W;
  localparam int XW            = csu_pkg::XLEN_W;
  localparam int NUM_RANDOM    = 48;
  localparam logic [6:0]  OPC_SYSTEM   = 7'b1110011;
  localparam logic [31:0] INST_MRET    = 32'h3020_0073;
  localparam logic [31:0] INST_SRET    = 32'h1020_0073;
  localparam logic [31:0] INST_ECALL   = 32'h0000_0073;
  localparam logic [31:0] INST_FENCE_I = 32'h0000_100f;

  typedef struct {
    logic [31:0]              inst;
    logic [RW-1:0]            rs1_rnid;
    logic                     rd_valid;
    logic [RW-1:0]            rd_rnid;
    logic                     fwd;
    csu_pkg::priv_t           priv;
    logic [RV_ENTRY_SIZE-1:0] index;
    int                       cycle;
    logic [XW-1:0]            old_value;
    logic [XW-1:0]            new_value;
    logic                     csr_wr;
  } op_rec_t;

  logic                         clk;
  logic                         reset_n;
  logic                         issue_valid;
  logic [31:0]                  issue_inst;
  logic [RV_ENTRY_SIZE-1:0]     issue_index;
  logic                         issue_rs1_valid;
  logic [RW-1:0]                issue_rs1_rnid;
  logic                         issue_rd_valid;
  logic [RW-1:0]                issue_rd_rnid;
  logic [TGT_BUS_SIZE-1:0]      tgt_valid;
  logic [TGT_BUS_SIZE*RW-1:0]   tgt_rnid;
  logic [TGT_BUS_SIZE*XW-1:0]   tgt_data;
  csu_pkg::priv_t               status_priv;
  logic                         phy_wr_valid;
  logic [RW-1:0]                phy_wr_rnid;
  logic [XW-1:0]                phy_wr_data;
  logic                         done_valid;
  logic [RV_ENTRY_SIZE-1:0]     done_index;
  logic                         except_valid;
  csu_pkg::except_t             except_type;
  logic                         fence_i;

  logic [31:0]   lcg_state;
  logic [XW-1:0] model_regs [PHY_REGS];
  logic [XW-1:0] model_csr [4];
  op_rec_t       stim_q [$];
  op_rec_t       flight_q [$];
  int            limit;
  int            run_cycles = 0;

  tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(4)) u_tb_clock_gen (
    .o_clk     (clk),
    .o_reset_n (reset_n)
  );

  csu_top #(
    .RV_ENTRY_SIZE (RV_ENTRY_SIZE),
    .TGT_BUS_SIZE  (TGT_BUS_SIZE),
    .PHY_REGS      (PHY_REGS)
  ) u_csu_top (
    .i_clk             (clk),
    .i_reset_n         (reset_n),
    .i_issue_valid     (issue_valid),
    .i_issue_inst      (issue_inst),
    .i_issue_index     (issue_index),
    .i_issue_rs1_valid (issue_rs1_valid),
    .i_issue_rs1_rnid  (issue_rs1_rnid),
    .i_issue_rd_valid  (issue_rd_valid),
    .i_issue_rd_rnid   (issue_rd_rnid),
    .i_tgt_valid       (tgt_valid),
    .i_tgt_rnid        (tgt_rnid),
    .i_tgt_data        (tgt_data),
    .i_status_priv     (status_priv),
    .o_phy_wr_valid    (phy_wr_valid),
    .o_phy_wr_rnid     (phy_wr_rnid),
    .o_phy_wr_data     (phy_wr_data),
    .o_done_valid      (done_valid),
    .o_done_index      (done_index),
    .o_except_valid    (except_valid),
    .o_except_type     (except_type),
    .o_fence_i         (fence_i)
  );

  function automatic logic [31:0] rand_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic csu_pkg::priv_t rand_priv();
    case (rand_next() % 3)
      0:       return csu_pkg::PRV_U;
      1:       return csu_pkg::PRV_S;
      default: return csu_pkg::PRV_M;
    endcase
  endfunction

  function automatic logic is_csr_op(logic [31:0] inst);
    return (inst[6:0] == OPC_SYSTEM) && (inst[13:12] != 2'b00);
  endfunction

  function automatic int csr_slot(logic [11:0] addr);
    case (addr)
      csu_pkg::CSR_MSCRATCH: return 0;
      csu_pkg::CSR_MEPC:     return 1;
      csu_pkg::CSR_MTVEC:    return 2;
      csu_pkg::CSR_SSCRATCH: return 3;
      default:               return -1;
    endcase
  endfunction

  function automatic csu_pkg::except_t expected_type(op_rec_t r);
    if (r.inst == INST_MRET) return csu_pkg::EXC_MRET;
    if (r.inst == INST_SRET) return csu_pkg::EXC_SRET;
    if (r.inst == INST_ECALL) begin
      case (r.priv)
        csu_pkg::PRV_U: return csu_pkg::EXC_ECALL_U;
        csu_pkg::PRV_S: return csu_pkg::EXC_ECALL_S;
        default:        return csu_pkg::EXC_ECALL_M;
      endcase
    end
    return csu_pkg::EXC_SILENT_FLUSH;
  endfunction

  // Operand selection and the RW, RS and RC update, seen in the ex2 cycle.
  function automatic op_rec_t ex2_result(op_rec_t r);
    logic [XW-1:0] operand;
    logic [XW-1:0] fwd_or;
    logic          hit;
    int            slot;
    fwd_or = '0;
    hit = 1'b0;
    for (int b = 0; b < TGT_BUS_SIZE; b++) begin
      if (tgt_valid[b] && r.rs1_rnid != '0 && tgt_rnid[b*RW +: RW] == r.rs1_rnid) begin
        hit = 1'b1;
        fwd_or = fwd_or | tgt_data[b*XW +: XW];
      end
    end
    if (r.inst[14]) operand = {27'd0, r.inst[19:15]};
    else if (hit) operand = fwd_or;
    else operand = model_regs[r.rs1_rnid];
    slot = csr_slot(r.inst[31:20]);
    r.old_value = (slot < 0 || !is_csr_op(r.inst)) ? '0 : model_csr[slot];
    case (r.inst[13:12])
      2'b01:   r.new_value = operand;
      2'b10:   r.new_value = r.old_value | operand;
      2'b11:   r.new_value = r.old_value & ~operand;
      default: r.new_value = r.old_value;
    endcase
    r.csr_wr = is_csr_op(r.inst) && !(r.inst[13] && r.inst[19:15] == 5'd0);
    return r;
  endfunction

  task automatic fail_stop();
    $display("** FAIL **");
    $fatal(1, "Run stopped at the first error.");
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      fail_stop();
    end
  endtask

  task automatic add_op(logic [31:0] inst, logic fwd, csu_pkg::priv_t priv);
    op_rec_t r;
    r.inst      = inst;
    r.rs1_rnid  = (inst[19:15] == 5'd0) ? '0 : RW'(1 + rand_next() % 63);
    r.rd_valid  = is_csr_op(inst);
    r.rd_rnid   = RW'(32 + rand_next() % 32); // Tags above 31 stay clear of the background buses.
    r.fwd       = fwd;
    r.priv      = priv;
    r.index     = RV_ENTRY_SIZE'(1 << (rand_next() % RV_ENTRY_SIZE));
    r.cycle     = 0;
    r.old_value = '0;
    r.new_value = '0;
    r.csr_wr    = 1'b0;
    stim_q.push_back(r);
  endtask

  task automatic add_csr(logic [2:0] f3, logic [11:0] addr, logic [4:0] rs1, logic fwd);
    add_op({addr, rs1, f3, 5'd10, OPC_SYSTEM}, fwd, rand_priv());
  endtask

  // Background traffic keeps bus 0 on tags 1 to 15 and bus 1 on tags 16 to 31.
  task automatic drive_tgt(logic fwd_en, logic [RW-1:0] fwd_rnid);
    logic [31:0] rv;
    rv = rand_next();
    tgt_valid            = fwd_en ? 2'b01 : rv[1:0];
    tgt_rnid[0 +: RW]    = fwd_en ? fwd_rnid : RW'(1 + rv[15:8] % 15);
    tgt_rnid[RW +: RW]   = RW'(16 + rv[23:16] % 16);
    tgt_data[0 +: XW]    = rand_next();
    tgt_data[XW +: XW]   = rand_next();
    for (int b = 0; b < TGT_BUS_SIZE; b++) begin
      if (tgt_valid[b] && tgt_rnid[b*RW +: RW] != '0) begin
        model_regs[tgt_rnid[b*RW +: RW]] = tgt_data[b*XW +: XW];
      end
    end
  endtask

  task automatic check_ex3(op_rec_t r);
    logic exc;
    int   slot;
    exc = r.csr_wr || r.inst == INST_MRET || r.inst == INST_SRET ||
          r.inst == INST_ECALL || r.inst == INST_FENCE_I;
    check_value("o_done_valid", 32'(done_valid), 32'd1);
    check_value("o_done_index", 32'(done_index), 32'(r.index));
    check_value("o_phy_wr_valid", 32'(phy_wr_valid), 32'(r.rd_valid));
    if (r.rd_valid) begin
      check_value("o_phy_wr_rnid", 32'(phy_wr_rnid), 32'(r.rd_rnid));
      check_value("o_phy_wr_data", phy_wr_data, r.old_value);
      model_regs[r.rd_rnid] = r.old_value;
    end
    check_value("o_except_valid", 32'(except_valid), 32'(exc));
    if (exc) check_value("o_except_type", 32'(except_type), 32'(expected_type(r)));
    check_value("o_fence_i", 32'(fence_i), 32'(r.inst == INST_FENCE_I));
    slot = csr_slot(r.inst[31:20]);
    if (r.csr_wr && slot >= 0) begin
      model_csr[slot] = r.new_value;
      if (slot == 1 || slot == 2) model_csr[slot][1:0] = 2'b00; // Mepc and mtvec are aligned.
    end
  endtask

  initial begin
    op_rec_t     r;
    logic [11:0] addrs [5];
    logic [2:0]  funct3s [6];
    logic [31:0] sys_insts [4];
    logic [31:0] rv;
    int          cycle;
    int          next_issue;
    int          ex2_pos;
    lcg_state       = 32'd42;
    issue_valid     = 1'b0;
    issue_inst      = '0;
    issue_index     = '0;
    issue_rs1_valid = 1'b0;
    issue_rs1_rnid  = '0;
    issue_rd_valid  = 1'b0;
    issue_rd_rnid   = '0;
    tgt_valid       = '0;
    tgt_rnid        = '0;
    tgt_data        = '0;
    status_priv     = csu_pkg::PRV_M;
    foreach (model_regs[i]) model_regs[i] = '0;
    foreach (model_csr[i]) model_csr[i] = '0;
    addrs = '{csu_pkg::CSR_MSCRATCH, csu_pkg::CSR_MEPC, csu_pkg::CSR_MTVEC,
              csu_pkg::CSR_SSCRATCH, 12'h7c0};
    funct3s   = '{3'b001, 3'b010, 3'b011, 3'b101, 3'b110, 3'b111};
    sys_insts = '{INST_MRET, INST_SRET, INST_ECALL, INST_FENCE_I};
    // Two writes and a read per CSR, the last address being unimplemented.
    foreach (addrs[i]) begin
      add_csr(3'b001, addrs[i], 5'd3, 1'b0);
      add_csr(3'b001, addrs[i], 5'd7, 1'b0);
      add_csr(3'b010, addrs[i], 5'd0, 1'b0);
    end
    foreach (addrs[i]) begin
      add_csr(3'b010, addrs[i], 5'd9, 1'b0);
      add_csr(3'b011, addrs[i], 5'd11, 1'b1);
      add_csr(3'b010, addrs[i], 5'd4, 1'b1);
      add_csr(3'b110, addrs[i], 5'd21, 1'b0);
      add_csr(3'b111, addrs[i], 5'd6, 1'b0);
      add_csr(3'b111, addrs[i], 5'd0, 1'b0);
      add_csr(3'b011, addrs[i], 5'd0, 1'b0);
    end
    add_op(INST_MRET, 1'b0, csu_pkg::PRV_M);
    add_op(INST_SRET, 1'b0, csu_pkg::PRV_S);
    add_op(INST_ECALL, 1'b0, csu_pkg::PRV_U);
    add_op(INST_ECALL, 1'b0, csu_pkg::PRV_S);
    add_op(INST_ECALL, 1'b0, csu_pkg::PRV_M);
    add_op(INST_FENCE_I, 1'b0, csu_pkg::PRV_M);
    for (int i = 0; i < NUM_RANDOM; i++) begin
      rv = rand_next();
      if (rv[2:0] == 3'd0) begin
        add_op(sys_insts[rv[5:4]], 1'b0, rand_priv());
      end else begin
        add_csr(funct3s[rv[31:16] % 6], addrs[rv[11:8] % 5],
                (rv[27:26] == 2'b00) ? 5'd0 : rv[24:20], rv[13]);
      end
    end
    limit = 40 * stim_q.size() + 100;
    cycle = 0;
    next_issue = 8; // Idle cycles first, so the target buses fill the registers.
    @(posedge reset_n);
    while (stim_q.size() > 0 || flight_q.size() > 0) begin
      @(negedge clk);
      cycle++;
      if (flight_q.size() > 0 && cycle - flight_q[0].cycle == 3) begin
        r = flight_q.pop_front();
        check_ex3(r);
      end else begin
        check_value("o_done_valid", 32'(done_valid), 32'd0);
        check_value("o_phy_wr_valid", 32'(phy_wr_valid), 32'd0);
        check_value("o_except_valid", 32'(except_valid), 32'd0);
        check_value("o_fence_i", 32'(fence_i), 32'd0);
      end
      ex2_pos = -1;
      foreach (flight_q[i]) begin
        if (cycle - flight_q[i].cycle == 2) ex2_pos = i;
      end
      if (ex2_pos >= 0) begin
        r = flight_q[ex2_pos];
        status_priv = r.priv;
        drive_tgt(r.fwd && r.rs1_rnid != '0 && !r.inst[14], r.rs1_rnid);
        flight_q[ex2_pos] = ex2_result(flight_q[ex2_pos]);
      end else begin
        drive_tgt(1'b0, '0);
      end
      if (stim_q.size() > 0 && cycle >= next_issue) begin
        r = stim_q.pop_front();
        r.cycle = cycle;
        issue_valid     = 1'b1;
        issue_inst      = r.inst;
        issue_index     = r.index;
        issue_rs1_valid = is_csr_op(r.inst) && !r.inst[14];
        issue_rs1_rnid  = r.rs1_rnid;
        issue_rd_valid  = r.rd_valid;
        issue_rd_rnid   = r.rd_rnid;
        flight_q.push_back(r);
        next_issue = cycle + 2 + int'(rand_next() % 2);
      end else begin
        issue_valid = 1'b0;
      end
    end
    $display("** PASS **");
    $finish;
  end

  always @(posedge clk) begin
    run_cycles <= run_cycles + 1;
    if (run_cycles >= limit) begin
      $display("Timeout: the run did not finish within %0d cycles.", limit);
      fail_stop();
    end
  end

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 4
) (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD / 2) o_clk = ~o_clk;
  end

  // Reset goes away on a falling edge, half a period clear of the rising edge.
  initial begin
    o_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_reset_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- design/csu_top.sv
`default_nettype none

module csu_top #(
  parameter int RV_ENTRY_SIZE = 8,
  parameter int TGT_BUS_SIZE  = 2,
  parameter int PHY_REGS      = 64
) (
  input  wire logic                                    i_clk,
  input  wire logic                                    i_reset_n,
  input  wire logic                                    i_issue_valid,
  input  wire logic [31:0]                             i_issue_inst,
  input  wire logic [RV_ENTRY_SIZE-1:0]                i_issue_index,
  input  wire logic                                    i_issue_rs1_valid,
  input  wire logic [csu_pkg::RNID_W-1:0]              i_issue_rs1_rnid,
  input  wire logic                                    i_issue_rd_valid,
  input  wire logic [csu_pkg::RNID_W-1:0]              i_issue_rd_rnid,
  input  wire logic [TGT_BUS_SIZE-1:0]                 i_tgt_valid,
  input  wire logic [TGT_BUS_SIZE*csu_pkg::RNID_W-1:0] i_tgt_rnid,
  input  wire logic [TGT_BUS_SIZE*csu_pkg::XLEN_W-1:0] i_tgt_data,
  input  wire csu_pkg::priv_t                          i_status_priv,
  output logic                                         o_phy_wr_valid,
  output logic [csu_pkg::RNID_W-1:0]                   o_phy_wr_rnid,
  output logic [csu_pkg::XLEN_W-1:0]                   o_phy_wr_data,
  output logic                                         o_done_valid,
  output logic [RV_ENTRY_SIZE-1:0]                     o_done_index,
  output logic                                         o_except_valid,
  output csu_pkg::except_t                             o_except_type,
  output logic                                         o_fence_i
);

  logic                              w_rs1_rd_valid;
  logic [csu_pkg::RNID_W-1:0]        w_rs1_rnid;
  logic [csu_pkg::XLEN_W-1:0]        w_rs1_data;
  logic                              w_csr_rd_valid;
  logic [csu_pkg::CSR_ADDR_W-1:0]    w_csr_rd_addr;
  logic [csu_pkg::XLEN_W-1:0]        w_csr_rd_data;
  logic                              w_csr_wr_valid;
  logic [csu_pkg::CSR_ADDR_W-1:0]    w_csr_wr_addr;
  logic [csu_pkg::XLEN_W-1:0]        w_csr_wr_data;

  csu_pipe #(
    .RV_ENTRY_SIZE (RV_ENTRY_SIZE),
    .TGT_BUS_SIZE  (TGT_BUS_SIZE)
  ) u_csu_pipe (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_issue_valid     (i_issue_valid),
    .i_issue_inst      (i_issue_inst),
    .i_issue_index     (i_issue_index),
    .i_issue_rs1_valid (i_issue_rs1_valid),
    .i_issue_rs1_rnid  (i_issue_rs1_rnid),
    .i_issue_rd_valid  (i_issue_rd_valid),
    .i_issue_rd_rnid   (i_issue_rd_rnid),
    .i_tgt_valid       (i_tgt_valid),
    .i_tgt_rnid        (i_tgt_rnid),
    .i_tgt_data        (i_tgt_data),
    .i_rs1_data        (w_rs1_data),
    .i_csr_rd_data     (w_csr_rd_data),
    .i_status_priv     (i_status_priv),
    .o_rs1_rd_valid    (w_rs1_rd_valid),
    .o_rs1_rnid        (w_rs1_rnid),
    .o_csr_rd_valid    (w_csr_rd_valid),
    .o_csr_rd_addr     (w_csr_rd_addr),
    .o_csr_wr_valid    (w_csr_wr_valid),
    .o_csr_wr_addr     (w_csr_wr_addr),
    .o_csr_wr_data     (w_csr_wr_data),
    .o_phy_wr_valid    (o_phy_wr_valid),
    .o_phy_wr_rnid     (o_phy_wr_rnid),
    .o_phy_wr_data     (o_phy_wr_data),
    .o_done_valid      (o_done_valid),
    .o_done_index      (o_done_index),
    .o_except_valid    (o_except_valid),
    .o_except_type     (o_except_type),
    .o_fence_i         (o_fence_i)
  );

  // The ex3 result goes back into the register file next to the target buses.
  phys_regfile #(
    .PHY_REGS     (PHY_REGS),
    .TGT_BUS_SIZE (TGT_BUS_SIZE)
  ) u_phys_regfile (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_rd_valid  (w_rs1_rd_valid),
    .i_rd_rnid   (w_rs1_rnid),
    .o_rd_data   (w_rs1_data),
    .i_tgt_valid (i_tgt_valid),
    .i_tgt_rnid  (i_tgt_rnid),
    .i_tgt_data  (i_tgt_data),
    .i_wr_valid  (o_phy_wr_valid),
    .i_wr_rnid   (o_phy_wr_rnid),
    .i_wr_data   (o_phy_wr_data)
  );

  csr_file u_csr_file (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_rd_valid (w_csr_rd_valid),
    .i_rd_addr  (w_csr_rd_addr),
    .o_rd_data  (w_csr_rd_data),
    .i_wr_valid (w_csr_wr_valid),
    .i_wr_addr  (w_csr_wr_addr),
    .i_wr_data  (w_csr_wr_data)
  );

endmodule

`default_nettype wire

//--- design/csu_pipe.sv
`default_nettype none

module csu_pipe #(
  parameter int RV_ENTRY_SIZE = 8,
  parameter int TGT_BUS_SIZE  = 2
) (
  input  wire logic                                       i_clk,
  input  wire logic                                       i_reset_n,
  input  wire logic                                       i_issue_valid,
  input  wire logic [31:0]                                i_issue_inst,
  input  wire logic [RV_ENTRY_SIZE-1:0]                   i_issue_index,
  input  wire logic                                       i_issue_rs1_valid,
  input  wire logic [csu_pkg::RNID_W-1:0]                 i_issue_rs1_rnid,
  input  wire logic                                       i_issue_rd_valid,
  input  wire logic [csu_pkg::RNID_W-1:0]                 i_issue_rd_rnid,
  input  wire logic [TGT_BUS_SIZE-1:0]                    i_tgt_valid,
  input  wire logic [TGT_BUS_SIZE*csu_pkg::RNID_W-1:0]    i_tgt_rnid,
  input  wire logic [TGT_BUS_SIZE*csu_pkg::XLEN_W-1:0]    i_tgt_data,
  input  wire logic [csu_pkg::XLEN_W-1:0]                 i_rs1_data,
  input  wire logic [csu_pkg::XLEN_W-1:0]                 i_csr_rd_data,
  input  wire csu_pkg::priv_t                             i_status_priv,
  output logic                                            o_rs1_rd_valid,
  output logic [csu_pkg::RNID_W-1:0]                      o_rs1_rnid,
  output logic                                            o_csr_rd_valid,
  output logic [csu_pkg::CSR_ADDR_W-1:0]                  o_csr_rd_addr,
  output logic                                            o_csr_wr_valid,
  output logic [csu_pkg::CSR_ADDR_W-1:0]                  o_csr_wr_addr,
  output logic [csu_pkg::XLEN_W-1:0]                      o_csr_wr_data,
  output logic                                            o_phy_wr_valid,
  output logic [csu_pkg::RNID_W-1:0]                      o_phy_wr_rnid,
  output logic [csu_pkg::XLEN_W-1:0]                      o_phy_wr_data,
  output logic                                            o_done_valid,
  output logic [RV_ENTRY_SIZE-1:0]                        o_done_index,
  output logic                                            o_except_valid,
  output csu_pkg::except_t                                o_except_type,
  output logic                                            o_fence_i
);

  typedef struct packed {
    csu_pkg::op_t                    op;
    logic                            is_imm;
    logic                            is_mret;
    logic                            is_sret;
    logic                            is_ecall;
    logic                            is_fence_i;
    logic [4:0]                      rs1_idx;
    logic                            rs1_valid;
    logic [csu_pkg::RNID_W-1:0]      rs1_rnid;
    logic                            rd_valid;
    logic [csu_pkg::RNID_W-1:0]      rd_rnid;
    logic [csu_pkg::CSR_ADDR_W-1:0]  csr_addr;
    logic [RV_ENTRY_SIZE-1:0]        index;
  } stage_t;

  stage_t                        w_ex0;
  stage_t                        r_ex1;
  stage_t                        r_ex2;
  stage_t                        r_ex3;
  logic                          r_ex1_valid;
  logic                          r_ex2_valid;
  logic                          r_ex3_valid;
  logic [TGT_BUS_SIZE-1:0]       w_fwd_hit;
  logic [csu_pkg::XLEN_W-1:0]    w_fwd_data;
  logic [csu_pkg::XLEN_W-1:0]    w_ex2_operand;
  logic [csu_pkg::XLEN_W-1:0]    w_ex2_new_value;
  logic [csu_pkg::XLEN_W-1:0]    r_ex3_new_value;
  logic [csu_pkg::XLEN_W-1:0]    r_ex3_old_value;
  logic                          w_ex3_wr_skip;

  csu_decoder u_csu_decoder (
    .i_inst       (i_issue_inst),
    .o_op         (w_ex0.op),
    .o_is_imm     (w_ex0.is_imm),
    .o_is_mret    (w_ex0.is_mret),
    .o_is_sret    (w_ex0.is_sret),
    .o_is_ecall   (w_ex0.is_ecall),
    .o_is_fence_i (w_ex0.is_fence_i)
  );

  assign w_ex0.rs1_idx   = i_issue_inst[19:15];
  assign w_ex0.rs1_valid = i_issue_rs1_valid;
  assign w_ex0.rs1_rnid  = i_issue_rs1_rnid;
  assign w_ex0.rd_valid  = i_issue_rd_valid;
  assign w_ex0.rd_rnid   = i_issue_rd_rnid;
  assign w_ex0.csr_addr  = i_issue_inst[31:20];
  assign w_ex0.index     = i_issue_index;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_valid <= 1'b0;
      r_ex2_valid <= 1'b0;
      r_ex3_valid <= 1'b0;
    end else begin
      r_ex1_valid <= i_issue_valid;
      r_ex2_valid <= r_ex1_valid;
      r_ex3_valid <= r_ex2_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex1           <= w_ex0;
    r_ex2           <= r_ex1;
    r_ex3           <= r_ex2;
    r_ex3_new_value <= w_ex2_new_value;
    r_ex3_old_value <= i_csr_rd_data;
  end

  assign o_rs1_rd_valid = r_ex1_valid & r_ex1.rs1_valid;
  assign o_rs1_rnid     = r_ex1.rs1_rnid;

  // Physical register 0 is hard zero and is never forwarded.
  always_comb begin
    w_fwd_data = '0;
    for (int b = 0; b < TGT_BUS_SIZE; b++) begin
      w_fwd_hit[b] = r_ex2.rs1_valid & i_tgt_valid[b] & (r_ex2.rs1_rnid != '0) &
                     (i_tgt_rnid[b*csu_pkg::RNID_W +: csu_pkg::RNID_W] == r_ex2.rs1_rnid);
      if (w_fwd_hit[b]) begin
        w_fwd_data = w_fwd_data | i_tgt_data[b*csu_pkg::XLEN_W +: csu_pkg::XLEN_W];
      end
    end
  end

  always_comb begin
    if (r_ex2.is_imm) begin
      w_ex2_operand = {{(csu_pkg::XLEN_W-5){1'b0}}, r_ex2.rs1_idx};
    end else if (|w_fwd_hit) begin
      w_ex2_operand = w_fwd_data;
    end else if (r_ex2.rs1_valid) begin
      w_ex2_operand = i_rs1_data;
    end else begin
      w_ex2_operand = '0;
    end
  end

  assign o_csr_rd_valid = r_ex2_valid & (r_ex2.op != csu_pkg::OP_NONE);
  assign o_csr_rd_addr  = r_ex2.csr_addr;

  always_comb begin
    case (r_ex2.op)
      csu_pkg::OP_RW: w_ex2_new_value = w_ex2_operand;
      csu_pkg::OP_RS: w_ex2_new_value = i_csr_rd_data | w_ex2_operand;
      csu_pkg::OP_RC: w_ex2_new_value = i_csr_rd_data & ~w_ex2_operand;
      default:        w_ex2_new_value = i_csr_rd_data;
    endcase
  end

  // Set and clear with x0 or a zero immediate only read the CSR.
  assign w_ex3_wr_skip = ((r_ex3.op == csu_pkg::OP_RS) | (r_ex3.op == csu_pkg::OP_RC)) &
                         (r_ex3.rs1_idx == 5'd0);

  assign o_csr_wr_valid = r_ex3_valid & (r_ex3.op != csu_pkg::OP_NONE) & !w_ex3_wr_skip;
  assign o_csr_wr_addr  = r_ex3.csr_addr;
  assign o_csr_wr_data  = r_ex3_new_value;

  assign o_phy_wr_valid = r_ex3_valid & r_ex3.rd_valid;
  assign o_phy_wr_rnid  = r_ex3.rd_rnid;
  assign o_phy_wr_data  = r_ex3_old_value; // Rd gets the value before the update.

  assign o_done_valid   = r_ex3_valid;
  assign o_done_index   = r_ex3.index;
  assign o_except_valid = o_csr_wr_valid |
                          (r_ex3_valid & (r_ex3.is_mret | r_ex3.is_sret |
                                          r_ex3.is_ecall | r_ex3.is_fence_i));
  assign o_fence_i      = r_ex3_valid & r_ex3.is_fence_i;

  always_comb begin
    if (r_ex3.is_mret) begin
      o_except_type = csu_pkg::EXC_MRET;
    end else if (r_ex3.is_sret) begin
      o_except_type = csu_pkg::EXC_SRET;
    end else if (r_ex3.is_ecall) begin
      case (i_status_priv)
        csu_pkg::PRV_U: o_except_type = csu_pkg::EXC_ECALL_U;
        csu_pkg::PRV_S: o_except_type = csu_pkg::EXC_ECALL_S;
        default:        o_except_type = csu_pkg::EXC_ECALL_M;
      endcase
    end else begin
      o_except_type = csu_pkg::EXC_SILENT_FLUSH;
    end
  end

endmodule

`default_nettype wire

//--- design/csr_file.sv
`default_nettype none

module csr_file (
  input  wire logic                               i_clk,
  input  wire logic                               i_reset_n,
  input  wire logic                               i_rd_valid,
  input  wire logic [csu_pkg::CSR_ADDR_W-1:0]     i_rd_addr,
  output logic [csu_pkg::XLEN_W-1:0]              o_rd_data,
  input  wire logic                               i_wr_valid,
  input  wire logic [csu_pkg::CSR_ADDR_W-1:0]     i_wr_addr,
  input  wire logic [csu_pkg::XLEN_W-1:0]         i_wr_data
);

  logic [csu_pkg::XLEN_W-1:0] r_mscratch;
  logic [csu_pkg::XLEN_W-1:0] r_mepc;
  logic [csu_pkg::XLEN_W-1:0] r_mtvec;
  logic [csu_pkg::XLEN_W-1:0] r_sscratch;
  logic [csu_pkg::XLEN_W-1:0] w_wr_aligned;

  // Mepc and mtvec hold word-aligned addresses.
  assign w_wr_aligned = {i_wr_data[csu_pkg::XLEN_W-1:2], 2'b00};

  always_comb begin
    o_rd_data = '0;
    if (i_rd_valid) begin
      case (i_rd_addr)
        csu_pkg::CSR_MSCRATCH: o_rd_data = r_mscratch;
        csu_pkg::CSR_MEPC:     o_rd_data = r_mepc;
        csu_pkg::CSR_MTVEC:    o_rd_data = r_mtvec;
        csu_pkg::CSR_SSCRATCH: o_rd_data = r_sscratch;
        default:               o_rd_data = '0; // Unimplemented CSRs read as zero.
      endcase
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_mscratch <= '0;
      r_mepc     <= '0;
      r_mtvec    <= '0;
      r_sscratch <= '0;
    end else if (i_wr_valid) begin
      case (i_wr_addr)
        csu_pkg::CSR_MSCRATCH: r_mscratch <= i_wr_data;
        csu_pkg::CSR_MEPC:     r_mepc     <= w_wr_aligned;
        csu_pkg::CSR_MTVEC:    r_mtvec    <= w_wr_aligned;
        csu_pkg::CSR_SSCRATCH: r_sscratch <= i_wr_data;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/phys_regfile.sv
`default_nettype none

module phys_regfile #(
  parameter int PHY_REGS     = 64,
  parameter int TGT_BUS_SIZE = 2
) (
  input  wire logic                                    i_clk,
  input  wire logic                                    i_reset_n,
  input  wire logic                                    i_rd_valid,
  input  wire logic [csu_pkg::RNID_W-1:0]              i_rd_rnid,
  output logic [csu_pkg::XLEN_W-1:0]                   o_rd_data,
  input  wire logic [TGT_BUS_SIZE-1:0]                 i_tgt_valid,
  input  wire logic [TGT_BUS_SIZE*csu_pkg::RNID_W-1:0] i_tgt_rnid,
  input  wire logic [TGT_BUS_SIZE*csu_pkg::XLEN_W-1:0] i_tgt_data,
  input  wire logic                                    i_wr_valid,
  input  wire logic [csu_pkg::RNID_W-1:0]              i_wr_rnid,
  input  wire logic [csu_pkg::XLEN_W-1:0]              i_wr_data
);

  logic [csu_pkg::XLEN_W-1:0] r_regs [PHY_REGS];
  logic [csu_pkg::XLEN_W-1:0] w_rd_word;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int r = 0; r < PHY_REGS; r++) begin
        r_regs[r] <= '0;
      end
    end else begin
      for (int b = 0; b < TGT_BUS_SIZE; b++) begin
        if (i_tgt_valid[b] && i_tgt_rnid[b*csu_pkg::RNID_W +: csu_pkg::RNID_W] != '0) begin
          r_regs[i_tgt_rnid[b*csu_pkg::RNID_W +: csu_pkg::RNID_W]] <=
            i_tgt_data[b*csu_pkg::XLEN_W +: csu_pkg::XLEN_W];
        end
      end
      if (i_wr_valid && i_wr_rnid != '0) begin
        r_regs[i_wr_rnid] <= i_wr_data;
      end
    end
  end

  // A write in the read cycle is passed through, so no bus result is lost between ex1 and ex2.
  always_comb begin
    w_rd_word = r_regs[i_rd_rnid];
    for (int b = 0; b < TGT_BUS_SIZE; b++) begin
      if (i_tgt_valid[b] && i_tgt_rnid[b*csu_pkg::RNID_W +: csu_pkg::RNID_W] == i_rd_rnid) begin
        w_rd_word = i_tgt_data[b*csu_pkg::XLEN_W +: csu_pkg::XLEN_W];
      end
    end
    if (i_wr_valid && i_wr_rnid == i_rd_rnid) begin
      w_rd_word = i_wr_data;
    end
    if (i_rd_rnid == '0) begin
      w_rd_word = '0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rd_valid) begin
      o_rd_data <= w_rd_word;
    end
  end

endmodule

`default_nettype wire

//--- design/csu_decoder.sv
`default_nettype none

module csu_decoder (
  input  wire logic [31:0]  i_inst,
  output csu_pkg::op_t      o_op,
  output logic              o_is_imm,
  output logic              o_is_mret,
  output logic              o_is_sret,
  output logic              o_is_ecall,
  output logic              o_is_fence_i
);

  localparam logic [6:0]  OPC_SYSTEM   = 7'b1110011;
  localparam logic [6:0]  OPC_MISC_MEM = 7'b0001111;
  localparam logic [31:0] INST_MRET    = 32'h3020_0073;
  localparam logic [31:0] INST_SRET    = 32'h1020_0073;
  localparam logic [31:0] INST_ECALL   = 32'h0000_0073;

  logic [6:0] w_opcode;
  logic [2:0] w_funct3;
  logic       w_is_system;

  assign w_opcode    = i_inst[6:0];
  assign w_funct3    = i_inst[14:12];
  assign w_is_system = (w_opcode == OPC_SYSTEM);

  always_comb begin
    o_op = csu_pkg::OP_NONE;
    if (w_is_system) begin
      case (w_funct3[1:0])
        2'b01:   o_op = csu_pkg::OP_RW;
        2'b10:   o_op = csu_pkg::OP_RS;
        2'b11:   o_op = csu_pkg::OP_RC;
        default: o_op = csu_pkg::OP_NONE; // funct3 of zero is MRET, SRET or ECALL.
      endcase
    end
  end

  // Bit 2 of funct3 turns the rs1 field into a 5-bit immediate.
  assign o_is_imm = w_is_system & w_funct3[2] & (w_funct3[1:0] != 2'b00);

  assign o_is_mret    = (i_inst == INST_MRET);
  assign o_is_sret    = (i_inst == INST_SRET);
  assign o_is_ecall   = (i_inst == INST_ECALL);
  assign o_is_fence_i = (w_opcode == OPC_MISC_MEM) & (w_funct3 == 3'b001);

endmodule

`default_nettype wire

//--- design/csu_pkg.sv
`default_nettype none

package csu_pkg;

  localparam int XLEN_W     = 32;
  localparam int RNID_W     = 6;
  localparam int CSR_ADDR_W = 12;

  // CSR operation taken from funct3 of the SYSTEM opcode.
  typedef enum logic [1:0] {
    OP_NONE = 2'b00,
    OP_RW   = 2'b01,
    OP_RS   = 2'b10,
    OP_RC   = 2'b11
  } op_t;

  // Exception codes carried by the done report. Every one of them asks for a flush.
  typedef enum logic [2:0] {
    EXC_MRET         = 3'd0,
    EXC_SRET         = 3'd1,
    EXC_ECALL_U      = 3'd2,
    EXC_ECALL_S      = 3'd3,
    EXC_ECALL_M      = 3'd4,
    EXC_SILENT_FLUSH = 3'd5
  } except_t;

  typedef enum logic [1:0] {
    PRV_U = 2'b00,
    PRV_S = 2'b01,
    PRV_M = 2'b11
  } priv_t;

  localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH = 12'h340;
  localparam logic [CSR_ADDR_W-1:0] CSR_MEPC     = 12'h341;
  localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC    = 12'h305;
  localparam logic [CSR_ADDR_W-1:0] CSR_SSCRATCH = 12'h140;

endpackage

`default_nettype wire
